// File: Makefile
# Verilator build and run of the wb_host testbench

VERILATOR ?= verilator
TOP       ?= tb_wb_host
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx 'RESULT: PASS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+source
source/wbh_pkg.sv
source/wbh_if.sv
source/wbh_req_ctrl.sv
source/wbh_regs.sv
source/wbh_ext_port.sv
source/wb_host.sv
tb/wbs_model.sv
tb/tb_wb_host.sv

// File: source/wb_host.sv
`include "wbh_defines.svh"

module wb_host (
   input  logic                         wbm_clk_i,
   input  logic                         wbm_rst_n,
   // host side
   input  logic                         wbm_cyc_i,
   input  logic                         wbm_stb_i,
   input  logic [`WBH_AW-1:0]           wbm_adr_i,
   input  logic                         wbm_we_i,
   input  logic [`WBH_DW-1:0]           wbm_dat_i,
   input  logic [`WBH_SEL_W-1:0]        wbm_sel_i,
   output logic [`WBH_DW-1:0]           wbm_dat_o,
   output logic                         wbm_ack_o,
   output logic                         wbm_err_o,
   // external slave side
   output logic                         wbs_cyc_o,
   output logic                         wbs_stb_o,
   output logic [`WBH_AW-1:0]           wbs_adr_o,
   output logic                         wbs_we_o,
   output logic [`WBH_DW-1:0]           wbs_dat_o,
   output logic [`WBH_SEL_W-1:0]        wbs_sel_o,
   input  logic [`WBH_DW-1:0]           wbs_dat_i,
   input  logic                         wbs_ack_i,
   input  logic                         wbs_err_i,
   // config outputs
   output logic [`WBH_NUM_SOFT_RST-1:0] soft_rst_n_o,
   output logic [`WBH_DW-1:0]           cfg_clk_ctrl1_o,
   output logic [`WBH_DW-1:0]           cfg_clk_ctrl2_o
);

   logic [`WBH_BANK_W-1:0] bank_sel;   // regs -> ext port

   wbh_reg_if u_reg_if ();
   wbh_ext_if u_ext_if ();

   //------------------------------------------------------------
   // request decode and host response
   //------------------------------------------------------------
   wbh_req_ctrl u_req_ctrl (
      .wbm_clk_i (wbm_clk_i),
      .wbm_rst_n (wbm_rst_n),
      .wbm_cyc_i (wbm_cyc_i),
      .wbm_stb_i (wbm_stb_i),
      .wbm_adr_i (wbm_adr_i),
      .wbm_we_i  (wbm_we_i),
      .wbm_dat_i (wbm_dat_i),
      .wbm_sel_i (wbm_sel_i),
      .wbm_dat_o (wbm_dat_o),
      .wbm_ack_o (wbm_ack_o),
      .wbm_err_o (wbm_err_o),
      .reg_if    (u_reg_if.ctrl),
      .ext_if    (u_ext_if.ctrl)
   );

   wbh_regs u_regs (
      .wbm_clk_i       (wbm_clk_i),
      .wbm_rst_n       (wbm_rst_n),
      .reg_if          (u_reg_if.regs),
      .bank_sel_o      (bank_sel),
      .soft_rst_n_o    (soft_rst_n_o),
      .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o),
      .cfg_clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

   wbh_ext_port u_ext_port (
      .wbm_clk_i  (wbm_clk_i),
      .wbm_rst_n  (wbm_rst_n),
      .bank_sel_i (bank_sel),
      .wbs_dat_i  (wbs_dat_i),
      .wbs_ack_i  (wbs_ack_i),
      .wbs_err_i  (wbs_err_i),
      .ext_if     (u_ext_if.port),
      .wbs_cyc_o  (wbs_cyc_o),
      .wbs_stb_o  (wbs_stb_o),
      .wbs_adr_o  (wbs_adr_o),
      .wbs_we_o   (wbs_we_o),
      .wbs_dat_o  (wbs_dat_o),
      .wbs_sel_o  (wbs_sel_o)
   );

endmodule

// File: source/wbh_defines.svh
`ifndef WBH_DEFINES_SVH
`define WBH_DEFINES_SVH

// bus widths
`define WBH_DW           32   // data
`define WBH_AW           32   // address
`define WBH_SEL_W        4    // byte enables
`define WBH_BANK_W       8    // bank select, prepended to external address

// address decode
`define WBH_LOCAL_BIT    23   // set -> local config registers
`define WBH_REG_IDX_LSB  2    // word index into the register bank

// reset values and counts
`define WBH_BANK_RST     8'h10
`define WBH_NUM_SOFT_RST 8

`endif

// File: source/wbh_ext_port.sv
`include "wbh_defines.svh"

module wbh_ext_port (
   input  logic                   wbm_clk_i,
   input  logic                   wbm_rst_n,
   input  logic [`WBH_BANK_W-1:0] bank_sel_i,
   input  logic [`WBH_DW-1:0]     wbs_dat_i,
   input  logic                   wbs_ack_i,
   input  logic                   wbs_err_i,
   wbh_ext_if.port                ext_if,
   output logic                   wbs_cyc_o,
   output logic                   wbs_stb_o,
   output logic [`WBH_AW-1:0]     wbs_adr_o,
   output logic                   wbs_we_o,
   output logic [`WBH_DW-1:0]     wbs_dat_o,
   output logic [`WBH_SEL_W-1:0]  wbs_sel_o
);

   logic launch;   // start a slave cycle
   logic done;     // slave answered this cycle

   // no relaunch while ack/err still pending toward the host
   assign launch = ext_if.ext_req && !wbs_stb_o && !ext_if.ack && !ext_if.err;
   assign done   = wbs_stb_o && (wbs_ack_i || wbs_err_i);

   //------------------------------------------------------------
   // slave cycle control
   //------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbs_cyc_o  <= 1'b0;
         wbs_stb_o  <= 1'b0;
         ext_if.ack <= 1'b0;
         ext_if.err <= 1'b0;
      end
      else
      begin
         if (launch)
         begin
            wbs_cyc_o <= 1'b1;
            wbs_stb_o <= 1'b1;
         end
         else if (done)   // end cycle on slave response
         begin
            wbs_cyc_o <= 1'b0;
            wbs_stb_o <= 1'b0;
         end
         ext_if.ack <= wbs_stb_o && wbs_ack_i;
         ext_if.err <= wbs_stb_o && wbs_err_i && !wbs_ack_i;
      end
   end

   // outbound payload, bank byte on top
   always_ff @(posedge wbm_clk_i)
   begin
      if (launch)
      begin
         wbs_adr_o <= {bank_sel_i, ext_if.adr[`WBH_AW-`WBH_BANK_W-1:0]};
         wbs_we_o  <= ext_if.we;
         wbs_dat_o <= ext_if.wdata;
         wbs_sel_o <= ext_if.sel;
      end
      if (wbs_stb_o && wbs_ack_i)
         ext_if.rdata <= wbs_dat_i;   // read data back to host side
   end

   // stall: strobe and the request behind it held until the slave responds
   a_stb_hold: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      (wbs_stb_o && !wbs_ack_i && !wbs_err_i) |=> (wbs_stb_o && ext_if.ext_req));

endmodule

// File: source/wbh_if.sv
`include "wbh_defines.svh"

//------------------------------------------------------------
// request path to the local register bank
//------------------------------------------------------------
interface wbh_reg_if;
   logic                      reg_req;  // level, held until ack
   logic                      we;
   wbh_pkg::wbh_reg_idx_e     idx;
   logic [`WBH_DW-1:0]        wdata;
   logic [`WBH_DW-1:0]        rdata;
   logic                      ack;      // single cycle

   modport ctrl (
      output reg_req, we, idx, wdata,
      input  rdata, ack
   );

   modport regs (
      input  reg_req, we, idx, wdata,
      output rdata, ack
   );
endinterface

//------------------------------------------------------------
// request path to the external wishbone port
//------------------------------------------------------------
interface wbh_ext_if;
   logic                      ext_req;  // level, held until ack/err
   logic [`WBH_AW-1:0]        adr;      // only low 24 bits go out
   logic                      we;
   logic [`WBH_DW-1:0]        wdata;
   logic [`WBH_SEL_W-1:0]     sel;
   logic [`WBH_DW-1:0]        rdata;
   logic                      ack;      // single cycle
   logic                      err;      // single cycle

   modport ctrl (
      output ext_req, adr, we, wdata, sel,
      input  rdata, ack, err
   );

   modport port (
      input  ext_req, adr, we, wdata, sel,
      output rdata, ack, err
   );
endinterface

// File: source/wbh_pkg.sv
`include "wbh_defines.svh"

package wbh_pkg;

   // local register map, word addressed
   typedef enum logic [1:0] {
      REG_GLB_CTRL  = 2'd0,  // soft resets + clock config
      REG_BANK_SEL  = 2'd1,  // upper address byte for external port
      REG_CLK_CTRL1 = 2'd2,
      REG_CLK_CTRL2 = 2'd3
   } wbh_reg_idx_e;

   //------------------------------------------------------------
   // global control word, msb first
   //------------------------------------------------------------
   typedef struct packed {
      logic [3:0]                   usb_clk_cfg;  // stored only
      logic [3:0]                   rsvd;
      logic [3:0]                   cpu_clk_cfg;
      logic [7:0]                   rtc_clk_cfg;
      logic [2:0]                   wb_clk_cfg;
      logic                         soft_rst_spare;
      logic [`WBH_NUM_SOFT_RST-1:0] soft_rst;     // active low subsystem resets
   } wbh_glb_ctrl_s;

   // raw view for bus access, field view for decode
   typedef union packed {
      logic [`WBH_DW-1:0] raw;
      wbh_glb_ctrl_s      fields;
   } wbh_glb_ctrl_u;

endpackage

// File: source/wbh_regs.sv
`include "wbh_defines.svh"

module wbh_regs (
   input  logic                         wbm_clk_i,
   input  logic                         wbm_rst_n,
   wbh_reg_if.regs                      reg_if,
   output logic [`WBH_BANK_W-1:0]       bank_sel_o,
   output logic [`WBH_NUM_SOFT_RST-1:0] soft_rst_n_o,
   output logic [`WBH_DW-1:0]           cfg_clk_ctrl1_o,
   output logic [`WBH_DW-1:0]           cfg_clk_ctrl2_o
);

   wbh_pkg::wbh_glb_ctrl_u glb_ctrl_q;   // global control, raw + fields
   logic                   access;       // first cycle of a pending request
   logic [`WBH_DW-1:0]     rd_mux;

   assign access = reg_if.reg_req && !reg_if.ack;

   //------------------------------------------------------------
   // config registers
   //------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_ctrl_q.raw  <= '0;              // all subsystems held in reset
         bank_sel_o      <= `WBH_BANK_RST;
         cfg_clk_ctrl1_o <= '0;
         cfg_clk_ctrl2_o <= '0;
      end
      else if (access && reg_if.we)
      begin
         case (reg_if.idx)
            wbh_pkg::REG_GLB_CTRL:  glb_ctrl_q.raw  <= reg_if.wdata;
            wbh_pkg::REG_BANK_SEL:  bank_sel_o      <= reg_if.wdata[`WBH_BANK_W-1:0];
            wbh_pkg::REG_CLK_CTRL1: cfg_clk_ctrl1_o <= reg_if.wdata;
            wbh_pkg::REG_CLK_CTRL2: cfg_clk_ctrl2_o <= reg_if.wdata;
            default:                ;
         endcase
      end
   end

   // soft resets straight from the decoded field
   assign soft_rst_n_o = glb_ctrl_q.fields.soft_rst;

   //------------------------------------------------------------
   // read back
   //------------------------------------------------------------
   always_comb
   begin
      case (reg_if.idx)
         wbh_pkg::REG_GLB_CTRL:  rd_mux = glb_ctrl_q.raw;
         wbh_pkg::REG_BANK_SEL:  rd_mux = {{(`WBH_DW-`WBH_BANK_W){1'b0}}, bank_sel_o};
         wbh_pkg::REG_CLK_CTRL1: rd_mux = cfg_clk_ctrl1_o;
         wbh_pkg::REG_CLK_CTRL2: rd_mux = cfg_clk_ctrl2_o;
         default:                rd_mux = '0;
      endcase
   end

   // captured with the ack, writes just see old value
   always_ff @(posedge wbm_clk_i)
   begin
      if (access)
         reg_if.rdata <= rd_mux;
   end

   // one ack per request level
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         reg_if.ack <= 1'b0;
      else
         reg_if.ack <= access;
   end

   // req_ctrl drops the level before a second ack could form
   a_ack_single: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      reg_if.ack |=> (!reg_if.ack && !reg_if.reg_req));

endmodule

// File: source/wbh_req_ctrl.sv
`include "wbh_defines.svh"

module wbh_req_ctrl (
   input  logic                  wbm_clk_i,
   input  logic                  wbm_rst_n,
   input  logic                  wbm_cyc_i,
   input  logic                  wbm_stb_i,
   input  logic [`WBH_AW-1:0]    wbm_adr_i,
   input  logic                  wbm_we_i,
   input  logic [`WBH_DW-1:0]    wbm_dat_i,
   input  logic [`WBH_SEL_W-1:0] wbm_sel_i,
   output logic [`WBH_DW-1:0]    wbm_dat_o,
   output logic                  wbm_ack_o,
   output logic                  wbm_err_o,
   wbh_reg_if.ctrl               reg_if,
   wbh_ext_if.ctrl               ext_if
);

   logic                  req_q;     // pending request level
   logic [`WBH_AW-1:0]    adr_q;
   logic                  we_q;
   logic [`WBH_DW-1:0]    dat_q;
   logic [`WBH_SEL_W-1:0] sel_q;
   logic                  rsp_ack;   // internal ack from either target
   logic                  rsp_err;

   assign rsp_ack = reg_if.ack | ext_if.ack;
   assign rsp_err = ext_if.err;   // local bank never errors

   //------------------------------------------------------------
   // request stage
   //------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         req_q <= 1'b0;
      else   // hold off while a response is on its way back
         req_q <= wbm_cyc_i && wbm_stb_i && !rsp_ack && !rsp_err
                  && !wbm_ack_o && !wbm_err_o;
   end

   // host keeps these stable during the cycle
   always_ff @(posedge wbm_clk_i)
   begin
      if (wbm_stb_i)
      begin
         adr_q <= wbm_adr_i;
         we_q  <= wbm_we_i;
         dat_q <= wbm_dat_i;
         sel_q <= wbm_sel_i;
      end
   end

   // local vs external decode on bit 23
   assign reg_if.reg_req = req_q && adr_q[`WBH_LOCAL_BIT];
   assign reg_if.we      = we_q;
   assign reg_if.idx     = wbh_pkg::wbh_reg_idx_e'(adr_q[`WBH_REG_IDX_LSB+1:`WBH_REG_IDX_LSB]);
   assign reg_if.wdata   = dat_q;

   assign ext_if.ext_req = req_q && !adr_q[`WBH_LOCAL_BIT];
   assign ext_if.adr     = adr_q;
   assign ext_if.we      = we_q;
   assign ext_if.wdata   = dat_q;
   assign ext_if.sel     = sel_q;

   //------------------------------------------------------------
   // host response, one cycle behind the target
   //------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbm_ack_o <= 1'b0;
         wbm_err_o <= 1'b0;
      end
      else
      begin
         wbm_ack_o <= rsp_ack;
         wbm_err_o <= rsp_err;
      end
   end

   // last read data stays on the bus
   always_ff @(posedge wbm_clk_i)
   begin
      if (reg_if.ack)
         wbm_dat_o <= reg_if.rdata;
      else if (ext_if.ack)
         wbm_dat_o <= ext_if.rdata;
   end

   // one target answers per request, so never both
   a_ack_err_excl: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !(wbm_ack_o && wbm_err_o));

endmodule

// File: tb/tb_wb_host.sv
module tb_wb_host;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_ROWS   = 17;
   localparam int MAX_WAIT   = 20;   // edges per access before giving up

   // extra check applied after the access
   typedef enum logic [2:0] {
      CHK_NONE,
      CHK_SOFT,    // soft_rst_n_o against low byte
      CHK_CLK1,
      CHK_CLK2,
      CHK_SADR,    // slave side address
      CHK_SWR      // write as recorded by the slave
   } chk_e;

   typedef struct packed {
      logic        wr;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic [31:0] exp_dat;
      logic        exp_err;
      chk_e        chk;
      logic [31:0] exp_sadr;
   } row_t;

   logic        wbm_clk_i;
   logic        wbm_rst_n;
   logic        wbm_cyc_i;
   logic        wbm_stb_i;
   logic [31:0] wbm_adr_i;
   logic        wbm_we_i;
   logic [31:0] wbm_dat_i;
   logic [3:0]  wbm_sel_i;
   logic [31:0] wbm_dat_o;
   logic        wbm_ack_o;
   logic        wbm_err_o;
   logic        wbs_cyc_o;
   logic        wbs_stb_o;
   logic [31:0] wbs_adr_o;
   logic        wbs_we_o;
   logic [31:0] wbs_dat_o;
   logic [3:0]  wbs_sel_o;
   logic [31:0] wbs_dat_i;
   logic        wbs_ack_i;
   logic        wbs_err_i;
   logic [7:0]  soft_rst_n_o;
   logic [31:0] cfg_clk_ctrl1_o;
   logic [31:0] cfg_clk_ctrl2_o;
   logic [31:0] last_adr;
   logic [31:0] last_dat;
   logic [3:0]  last_sel;

   row_t   tbl [NUM_ROWS];
   integer seed;
   int     n_pass;
   int     n_fail;
   logic   row_ok;

   wb_host dut (.*);

   wbs_model u_slave (
      .wbm_clk_i  (wbm_clk_i),
      .wbm_rst_n  (wbm_rst_n),
      .cyc_i      (wbs_cyc_o),
      .stb_i      (wbs_stb_o),
      .adr_i      (wbs_adr_o),
      .we_i       (wbs_we_o),
      .dat_i      (wbs_dat_o),
      .sel_i      (wbs_sel_o),
      .dat_o      (wbs_dat_i),
      .ack_o      (wbs_ack_i),
      .err_o      (wbs_err_i),
      .last_adr_o (last_adr),
      .last_dat_o (last_dat),
      .last_sel_o (last_sel)
   );

   initial wbm_clk_i = 1'b0;
   always #(CLK_PERIOD/2) wbm_clk_i = ~wbm_clk_i;

   // ------------------------------------------------------------
   // stimulus table
   // ------------------------------------------------------------
   task automatic build_table;
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      // reset values of the local bank
      tbl[0]  = '{1'b0, 32'h0080_0000, 32'h0, 4'hf, 32'h0, 1'b0, CHK_NONE, 32'h0};
      tbl[1]  = '{1'b0, 32'h0080_0004, 32'h0, 4'hf, 32'h10, 1'b0, CHK_NONE, 32'h0};
      tbl[2]  = '{1'b0, 32'h0080_0008, 32'h0, 4'hf, 32'h0, 1'b0, CHK_NONE, 32'h0};
      tbl[3]  = '{1'b0, 32'h0080_000c, 32'h0, 4'hf, 32'h0, 1'b0, CHK_NONE, 32'h0};
      // external read, default bank 0x10
      tbl[4]  = '{1'b0, 32'h0012_3454, 32'h0, 4'hf, ~32'h1012_3454, 1'b0, CHK_SADR,
                  32'h1012_3454};
      tbl[5]  = '{1'b1, 32'h0080_0000, r0, 4'hf, r0, 1'b0, CHK_SOFT, 32'h0};
      tbl[6]  = '{1'b0, 32'h0080_0000, 32'h0, 4'hf, r0, 1'b0, CHK_NONE, 32'h0};
      tbl[7]  = '{1'b1, 32'h0080_0004, 32'h5a5a_01a5, 4'hf, 32'h0, 1'b0, CHK_NONE, 32'h0};
      tbl[8]  = '{1'b0, 32'h0080_0004, 32'h0, 4'hf, 32'h0000_00a5, 1'b0, CHK_NONE, 32'h0};
      tbl[9]  = '{1'b1, 32'h0080_0008, r1, 4'hf, r1, 1'b0, CHK_CLK1, 32'h0};
      tbl[10] = '{1'b0, 32'h0080_0008, 32'h0, 4'hf, r1, 1'b0, CHK_NONE, 32'h0};
      tbl[11] = '{1'b1, 32'h0080_000c, r2, 4'hf, r2, 1'b0, CHK_CLK2, 32'h0};
      tbl[12] = '{1'b0, 32'h0080_000c, 32'h0, 4'hf, r2, 1'b0, CHK_NONE, 32'h0};
      // host top byte replaced by bank 0xa5
      tbl[13] = '{1'b1, 32'h7700_0abc, r3, 4'b0110, r3, 1'b0, CHK_SWR, 32'ha500_0abc};
      tbl[14] = '{1'b1, 32'h0080_0004, 32'h0000_00ee, 4'hf, 32'h0, 1'b0, CHK_NONE, 32'h0};
      tbl[15] = '{1'b0, 32'h0000_0010, 32'h0, 4'hf, 32'h0, 1'b1, CHK_SADR, 32'hee00_0010};
      tbl[16] = '{1'b1, 32'h0000_0020, r3, 4'hf, 32'h0, 1'b1, CHK_NONE, 32'h0};
   endtask

   task automatic report_mismatch(input int idx, input string what,
                                  input logic [31:0] got, input logic [31:0] want);
      $display("MISMATCH at %0d ns: test %0d %s got %h expected %h",
               $time, idx, what, got, want);
      row_ok = 1'b0;
   endtask

   task automatic finish_test(input int idx);
      if (row_ok)
      begin
         n_pass++;
         $display("test %0d passed", idx);
      end
      else
      begin
         n_fail++;
         $display("test %0d failed", idx);
      end
   endtask

   // outputs right after reset release
   task automatic check_reset_outputs;
      row_ok = 1'b1;
      if (soft_rst_n_o !== 8'h00)
         report_mismatch(-1, "soft_rst_n_o", {24'h0, soft_rst_n_o}, 32'h0);
      if (wbs_stb_o !== 1'b0)
         report_mismatch(-1, "wbs_stb_o", {31'h0, wbs_stb_o}, 32'h0);
      if (wbs_cyc_o !== 1'b0)
         report_mismatch(-1, "wbs_cyc_o", {31'h0, wbs_cyc_o}, 32'h0);
      if (wbm_ack_o !== 1'b0 || wbm_err_o !== 1'b0)
         report_mismatch(-1, "ack/err", {30'h0, wbm_ack_o, wbm_err_o}, 32'h0);
      finish_test(-1);
   endtask

   // ------------------------------------------------------------
   // one bus access, entered 1 ns after an edge
   // ------------------------------------------------------------
   task automatic run_row(input int idx);
      row_t r;
      int   edges;
      r      = tbl[idx];
      edges  = 0;
      row_ok = 1'b1;
      wbm_cyc_i = 1'b1;
      wbm_stb_i = 1'b1;
      wbm_adr_i = r.adr;
      wbm_we_i  = r.wr;
      wbm_dat_i = r.dat;
      wbm_sel_i = r.sel;
      while (!(wbm_ack_o || wbm_err_o) && edges < MAX_WAIT)
      begin
         @(posedge wbm_clk_i);
         #1;
         edges++;
      end
      wbm_cyc_i = 1'b0;   // classic cycle ends after the response
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
      if (!(wbm_ack_o || wbm_err_o))
      begin
         $display("test %0d: bridge gave no ack or err within %0d cycles", idx, MAX_WAIT);
         row_ok = 1'b0;
      end
      else
      begin
         if (wbm_err_o !== r.exp_err)
            report_mismatch(idx, "wbm_err_o", {31'h0, wbm_err_o}, {31'h0, r.exp_err});
         if (wbm_ack_o !== !r.exp_err)
            report_mismatch(idx, "wbm_ack_o", {31'h0, wbm_ack_o}, {31'h0, !r.exp_err});
         if (r.adr[23] && edges != 3)   // local path is fixed latency
            report_mismatch(idx, "ack edge count", edges, 32'd3);
         if (!r.wr && !r.exp_err && wbm_dat_o !== r.exp_dat)
            report_mismatch(idx, "wbm_dat_o", wbm_dat_o, r.exp_dat);
         // slave cycle closed by the time the host sees the response
         if (wbs_cyc_o !== 1'b0 || wbs_stb_o !== 1'b0)
            report_mismatch(idx, "wbs_cyc_o/wbs_stb_o",
                            {30'h0, wbs_cyc_o, wbs_stb_o}, 32'h0);
         if (!r.adr[23] && wbs_we_o !== r.wr)
            report_mismatch(idx, "wbs_we_o", {31'h0, wbs_we_o}, {31'h0, r.wr});
         case (r.chk)
            CHK_SOFT:
               if (soft_rst_n_o !== r.exp_dat[7:0])
                  report_mismatch(idx, "soft_rst_n_o", {24'h0, soft_rst_n_o},
                                  {24'h0, r.exp_dat[7:0]});
            CHK_CLK1:
               if (cfg_clk_ctrl1_o !== r.exp_dat)
                  report_mismatch(idx, "cfg_clk_ctrl1_o", cfg_clk_ctrl1_o, r.exp_dat);
            CHK_CLK2:
               if (cfg_clk_ctrl2_o !== r.exp_dat)
                  report_mismatch(idx, "cfg_clk_ctrl2_o", cfg_clk_ctrl2_o, r.exp_dat);
            CHK_SADR:
               if (wbs_adr_o !== r.exp_sadr)
                  report_mismatch(idx, "wbs_adr_o", wbs_adr_o, r.exp_sadr);
            CHK_SWR:
            begin
               if (last_adr !== r.exp_sadr)
                  report_mismatch(idx, "slave write adr", last_adr, r.exp_sadr);
               if (last_dat !== r.exp_dat)
                  report_mismatch(idx, "slave write dat", last_dat, r.exp_dat);
               if (last_sel !== r.sel)
                  report_mismatch(idx, "slave write sel", {28'h0, last_sel}, {28'h0, r.sel});
            end
            default: ;
         endcase
      end
      finish_test(idx);
      @(posedge wbm_clk_i);   // idle edge with strobe low
      #1;
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial
   begin
      seed      = 32'h81e790a7;
      n_pass    = 0;
      n_fail    = 0;
      row_ok    = 1'b1;
      wbm_rst_n = 1'b0;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_adr_i = '0;
      wbm_we_i  = 1'b0;
      wbm_dat_i = '0;
      wbm_sel_i = '0;
      build_table();
      repeat (10) @(posedge wbm_clk_i);
      #1;
      wbm_rst_n = 1'b1;
      check_reset_outputs();
      for (int i = 0; i < NUM_ROWS; i++)
         run_row(i);
      $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
      if (n_fail == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   // watchdog, sized from the table length
   initial
   begin
      #(NUM_ROWS * MAX_WAIT * CLK_PERIOD);
      $display("watchdog expired before all tests finished");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: tb/wbs_model.sv
module wbs_model (
   input  logic        wbm_clk_i,
   input  logic        wbm_rst_n,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic [31:0] adr_i,
   input  logic        we_i,
   input  logic [31:0] dat_i,
   input  logic [3:0]  sel_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        err_o,
   output logic [31:0] last_adr_o,   // last acked write
   output logic [31:0] last_dat_o,
   output logic [3:0]  last_sel_o
);
   timeunit 1ns;
   timeprecision 1ps;

   int          wait_cnt;   // edges seen with strobe up
   logic [31:0] adr_s;      // values sampled on the edge
   logic [31:0] dat_s;
   logic [3:0]  sel_s;
   logic        we_s;

   initial
   begin
      dat_o      = '0;
      ack_o      = 1'b0;
      err_o      = 1'b0;
      last_adr_o = '0;
      last_dat_o = '0;
      last_sel_o = '0;
      wait_cnt   = 0;
   end

   // answers on the second edge that sees the strobe
   always @(posedge wbm_clk_i)
   begin
      adr_s = adr_i;
      dat_s = dat_i;
      sel_s = sel_i;
      we_s  = we_i;
      if (!wbm_rst_n || !(cyc_i && stb_i) || ack_o || err_o)
      begin
         wait_cnt = 0;
         #1;
         ack_o = 1'b0;   // single cycle response
         err_o = 1'b0;
      end
      else if (wait_cnt == 0)
         wait_cnt = 1;
      else
      begin
         wait_cnt = 0;
         #1;
         if (adr_s[31:24] == 8'hee)
            err_o = 1'b1;   // bank 0xee is unmapped
         else
         begin
            ack_o = 1'b1;
            dat_o = ~adr_s;   // read data follows the address
            if (we_s)
            begin
               last_adr_o = adr_s;
               last_dat_o = dat_s;
               last_sel_o = sel_s;
            end
         end
      end
   end

endmodule
